//--- core_fabric.f
hdl/fabric_pkg.sv
hdl/rr_arbiter.sv
hdl/ctrl_dispatch.sv
hdl/ctrl_collect.sv
hdl/msg_broadcast.sv
hdl/core_fabric.sv
bench/clk_gen.sv
bench/core_fabric_tb.sv

//--- Makefile
SRCS := $(shell cat core_fabric.f)

.PHONY: all run clean

all: obj_dir/Vcore_fabric_tb

obj_dir/Vcore_fabric_tb: core_fabric.f $(SRCS)
	verilator --binary --timing --assert \
	  --top-module core_fabric_tb -o Vcore_fabric_tb \
	  -f core_fabric.f

run: obj_dir/Vcore_fabric_tb
	./obj_dir/Vcore_fabric_tb | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- bench/core_fabric_tb.sv
`timescale 1ns/1ps

module core_fabric_tb;

  import fabric_pkg::*;

  localparam int CORE_COUNT = 16;
  localparam int TIMEOUT    = 2000;

  typedef struct packed {
    logic [3:0] dest;
    ctrl_beat_t beat;
  } routed_t;

  logic core_clk;
  logic core_rst;
  ctrl_beat_t ctrl_in;
  logic [3:0] ctrl_in_dest;
  logic ctrl_in_valid;
  logic ctrl_in_ready;
  ctrl_beat_t core_ctrl;
  logic [15:0] core_ctrl_valid;
  logic [15:0] core_ctrl_ready;
  ctrl_beat_t [15:0] core_ctrl_out;
  logic [15:0] core_ctrl_out_valid;
  logic [15:0] core_ctrl_out_ready;
  ctrl_beat_t ctrl_out;
  logic [3:0] ctrl_out_src;
  logic ctrl_out_valid;
  logic ctrl_out_ready;
  core_msg_t [15:0] msg_out;
  logic [15:0] msg_out_valid;
  logic [15:0] msg_out_ready;
  core_msg_t msg_in;
  logic [15:0] msg_in_valid;

  integer seed;
  int checks;
  int errors;
  int waited;
  logic disp_rand;
  logic lat_check;
  logic lat_pend;
  routed_t lat_beat;
  routed_t disp_exp;
  routed_t disp_q[$];
  int col_len[CORE_COUNT][4];
  int col_pkts[CORE_COUNT];
  int drv_pkt[CORE_COUNT];
  int drv_beat[CORE_COUNT];
  int obs_pkt[CORE_COUNT];
  int obs_beat;
  int col_done;
  int col_total;
  logic [3:0] obs_src;
  logic [3:0] col_ptr;
  logic in_pkt;
  logic [15:0] left;
  logic [15:0] took;
  logic [3:0] msg_ptr;
  logic [3:0] win;
  logic msg_pend;
  core_msg_t msg_exp;
  logic [15:0] mask_exp;
  int wins[CORE_COUNT];

  clk_gen clk_i (
    .core_clk(core_clk),
    .core_rst(core_rst)
  );

  core_fabric #(
    .CORE_COUNT(CORE_COUNT)
  ) dut_i (.*);

  // Next round-robin winner, scanning upward from the core after last
  function automatic logic [3:0] rr_next(input logic [15:0] req, input logic [3:0] last);
    logic [3:0] idx;
    rr_next = last;
    for (int i = CORE_COUNT; i >= 1; i--) begin
      idx = 4'((int'(last) + i) % CORE_COUNT);
      if (req[idx]) rr_next = idx;
    end
  endfunction

  // Every core except the sender
  function automatic logic [15:0] bcast_mask(input logic [3:0] sender);
    bcast_mask = ~(16'(1) << sender);
  endfunction

  // Beat payload tagged with core, packet and beat number
  function automatic logic [63:0] beat_data(input int c, input int p, input int b);
    beat_data = {8'(c), 8'(p), 8'(b), 40'hA5A5};
  endfunction

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout: no response from the DUT while %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic send_packet(input logic [3:0] dest, input int len);
    for (int b = 0; b < len; b++) begin
      ctrl_in_valid   = 1'b1;
      ctrl_in_dest    = dest;
      ctrl_in.data    = {$random(seed), $random(seed)};
      ctrl_in.last    = (b == len - 1);
      disp_q.push_back({dest, ctrl_in});
      waited = 0;
      @(negedge core_clk);
      while (!ctrl_in_ready) begin
        if (waited >= TIMEOUT) fail_timeout("waiting for ctrl_in_ready");
        @(negedge core_clk);
        waited++;
      end
      @(posedge core_clk);
      #1;
    end
    ctrl_in_valid = 1'b0;
  endtask

  task automatic drain_dispatch();
    waited = 0;
    while (disp_q.size() != 0) begin
      if (waited >= TIMEOUT) fail_timeout("draining dispatched beats");
      @(negedge core_clk);
      waited++;
    end
    @(posedge core_clk);
    #1;
  endtask

  task automatic run_collect();
    col_total = 0;
    col_done  = 0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      col_pkts[c] = (($random(seed) & 1) != 0 || c == 0 || c == 15) ? 3 : 0;
      col_total  += col_pkts[c];
      drv_pkt[c]  = 0;
      drv_beat[c] = 0;
      for (int p = 0; p < 4; p++) col_len[c][p] = 1 + ($random(seed) & 7);
    end
    waited = 0;
    while (col_done < col_total) begin
      @(posedge core_clk);
      #1;
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (took[c]) begin
          if (drv_beat[c] == col_len[c][drv_pkt[c]] - 1) begin
            drv_pkt[c]++;
            drv_beat[c] = 0;
          end else begin
            drv_beat[c]++;
          end
        end
        core_ctrl_out_valid[c] = (drv_pkt[c] < col_pkts[c]);
        core_ctrl_out[c].data  = beat_data(c, drv_pkt[c], drv_beat[c]);
        core_ctrl_out[c].last  = (drv_beat[c] == col_len[c][drv_pkt[c]] - 1);
      end
      ctrl_out_ready = (($random(seed) & 3) != 0);
      waited++;
      if (waited >= TIMEOUT) fail_timeout("collecting core packets");
    end
    core_ctrl_out_valid = '0;
    ctrl_out_ready      = 1'b1;
  endtask

  task automatic drive_msgs(input int cycles, input logic all_req);
    for (int n = 0; n < cycles; n++) begin
      @(posedge core_clk);
      #1;
      msg_out_valid = all_req ? '1 : 16'($random(seed) & $random(seed));
      for (int c = 0; c < CORE_COUNT; c++) begin
        msg_out[c] = 51'({$random(seed), $random(seed)});
      end
    end
    @(posedge core_clk);
    #1;
    msg_out_valid = '0;
  endtask

  // Core readies for the dispatch side
  initial begin
    core_ctrl_ready = '1;
    forever begin
      @(posedge core_clk);
      #1;
      core_ctrl_ready = disp_rand ? 16'($random(seed)) : '1;
    end
  end

  always @(negedge core_clk) begin
    took = core_ctrl_out_valid & core_ctrl_out_ready;
  end

  // Dispatch compare, in order and with 1 cycle latency when enabled
  always @(negedge core_clk) begin
    if (!core_rst) begin
      if (lat_pend) begin
        check("dispatch latency valid", 128'(core_ctrl_valid), 128'(16'(1) << lat_beat.dest));
        check("dispatch latency data", 128'(core_ctrl), 128'(lat_beat.beat));
      end
      lat_pend = lat_check && ctrl_in_valid && ctrl_in_ready;
      lat_beat = {ctrl_in_dest, ctrl_in};
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (core_ctrl_valid[c] && core_ctrl_ready[c]) begin
          if (disp_q.size() == 0) begin
            check("unexpected dispatch beat", 128'(c), 128'(16));
          end else begin
            disp_exp = disp_q.pop_front();
            check("dispatch destination", 128'(c), 128'(disp_exp.dest));
            check("dispatch beat", 128'(core_ctrl), 128'(disp_exp.beat));
          end
        end
      end
    end
  end

  // Collection compare
  always @(negedge core_clk) begin
    if (!core_rst && ctrl_out_valid && ctrl_out_ready) begin
      if (!in_pkt) begin
        for (int c = 0; c < CORE_COUNT; c++) left[c] = (obs_pkt[c] < col_pkts[c]);
        check("collect round-robin source", 128'(ctrl_out_src), 128'(rr_next(left, col_ptr)));
        obs_src  = ctrl_out_src;
        col_ptr  = ctrl_out_src;
        in_pkt   = 1'b1;
        obs_beat = 0;
      end
      check("collect source inside packet", 128'(ctrl_out_src), 128'(obs_src));
      if (obs_pkt[obs_src] >= col_pkts[obs_src]) begin
        check("collect extra packet", 128'(obs_pkt[obs_src]), 128'(col_pkts[obs_src]));
      end else begin
        check("collect beat data", 128'(ctrl_out.data),
              128'(beat_data(obs_src, obs_pkt[obs_src], obs_beat)));
        check("collect last", 128'(ctrl_out.last),
              128'(obs_beat == col_len[obs_src][obs_pkt[obs_src]] - 1));
      end
      if (ctrl_out.last) begin
        in_pkt = 1'b0;
        obs_pkt[obs_src]++;
        col_done++;
      end else begin
        obs_beat++;
      end
    end
  end

  // Broadcast compare
  always @(negedge core_clk) begin
    if (!core_rst) begin
      if (msg_pend) begin
        check("broadcast mask", 128'(msg_in_valid), 128'(mask_exp));
        check("broadcast message", 128'(msg_in), 128'(msg_exp));
      end else begin
        check("idle msg_in_valid", 128'(msg_in_valid), 128'(0));
      end
      msg_pend = |msg_out_valid;
      if (msg_pend) begin
        win = rr_next(msg_out_valid, msg_ptr);
        check("broadcast winner", 128'(msg_out_ready), 128'(16'(1) << win));
        msg_exp  = msg_out[win];
        mask_exp = bcast_mask(win);
        msg_ptr  = win;
        for (int c = 0; c < CORE_COUNT; c++) begin
          if (msg_out_ready[c]) wins[c]++;
        end
      end else begin
        check("idle msg_out_ready", 128'(msg_out_ready), 128'(0));
      end
    end
  end

  initial begin
    seed                = 41772;
    checks              = 0;
    errors              = 0;
    ctrl_in             = '0;
    ctrl_in_dest        = '0;
    ctrl_in_valid       = 1'b0;
    core_ctrl_out       = '0;
    core_ctrl_out_valid = '0;
    ctrl_out_ready      = 1'b1;
    msg_out             = '0;
    msg_out_valid       = '0;
    disp_rand           = 1'b0;
    lat_check           = 1'b0;
    lat_pend            = 1'b0;
    in_pkt              = 1'b0;
    msg_pend            = 1'b0;
    col_ptr             = 4'hF;
    msg_ptr             = 4'hF;
    for (int c = 0; c < CORE_COUNT; c++) begin
      obs_pkt[c]  = 0;
      col_pkts[c] = 0;
      wins[c]     = 0;
    end

    // Outputs stay quiet through reset and the cycle after
    waited = 0;
    while (core_rst !== 1'b0) begin
      if (waited >= TIMEOUT) fail_timeout("waiting for reset to end");
      @(negedge core_clk);
      waited++;
      if (core_rst) check("ctrl_in_ready in reset", 128'(ctrl_in_ready), 128'(0));
      check("core_ctrl_valid", 128'(core_ctrl_valid), 128'(0));
      check("ctrl_out_valid", 128'(ctrl_out_valid), 128'(0));
      check("msg_in_valid", 128'(msg_in_valid), 128'(0));
      check("core_ctrl_out_ready", 128'(core_ctrl_out_ready), 128'(0));
      check("msg_out_ready", 128'(msg_out_ready), 128'(0));
    end
    $display("Test reset finished, %0d errors so far", errors);

    @(posedge core_clk);
    #1;
    lat_check = 1'b1;
    for (int n = 0; n < 20; n++) send_packet(4'($random(seed)), 1 + ($random(seed) & 7));
    drain_dispatch();
    lat_check = 1'b0;
    $display("Test dispatch routing finished, %0d errors so far", errors);

    disp_rand = 1'b1;
    for (int n = 0; n < 20; n++) send_packet(4'($random(seed)), 1 + ($random(seed) & 7));
    drain_dispatch();
    disp_rand = 1'b0;
    $display("Test dispatch back-pressure finished, %0d errors so far", errors);

    run_collect();
    $display("Test collection finished, %0d errors so far", errors);

    // All cores request, so each one wins twice in 32 grants from core 0
    drive_msgs(32, 1'b1);
    for (int c = 0; c < CORE_COUNT; c++) check("broadcast wins per core", 128'(wins[c]), 128'(2));
    drive_msgs(60, 1'b0);
    @(posedge core_clk);
    #1;
    $display("Test broadcast finished, %0d errors so far", errors);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 8
) (
  output logic core_clk,
  output logic core_rst
);

  initial begin
    core_clk = 1'b0;
    forever #HALF_PERIOD core_clk = ~core_clk;
  end

  initial begin
    core_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge core_clk);
    #1 core_rst = 1'b0;
  end

endmodule

//--- hdl/core_fabric.sv
`timescale 1ns/1ps

module core_fabric #(
  parameter  int CORE_COUNT = 16,
  localparam int IDX_WIDTH  = $clog2(CORE_COUNT)
) (
  input  logic                                    core_clk,
  input  logic                                    core_rst,

  // Control stream from the scheduler
  input  fabric_pkg::ctrl_beat_t                  ctrl_in,
  input  logic [IDX_WIDTH-1:0]                    ctrl_in_dest,
  input  logic                                    ctrl_in_valid,
  output logic                                    ctrl_in_ready,

  // Control stream to the cores
  output fabric_pkg::ctrl_beat_t                  core_ctrl,
  output logic [CORE_COUNT-1:0]                   core_ctrl_valid,
  input  logic [CORE_COUNT-1:0]                   core_ctrl_ready,

  // Control streams from the cores
  input  fabric_pkg::ctrl_beat_t [CORE_COUNT-1:0] core_ctrl_out,
  input  logic [CORE_COUNT-1:0]                   core_ctrl_out_valid,
  output logic [CORE_COUNT-1:0]                   core_ctrl_out_ready,

  // Merged control stream back to the scheduler
  output fabric_pkg::ctrl_beat_t                  ctrl_out,
  output logic [IDX_WIDTH-1:0]                    ctrl_out_src,
  output logic                                    ctrl_out_valid,
  input  logic                                    ctrl_out_ready,

  // Core memory update messages
  input  fabric_pkg::core_msg_t [CORE_COUNT-1:0]  msg_out,
  input  logic [CORE_COUNT-1:0]                   msg_out_valid,
  output logic [CORE_COUNT-1:0]                   msg_out_ready,
  output fabric_pkg::core_msg_t                   msg_in,
  output logic [CORE_COUNT-1:0]                   msg_in_valid
);

  ctrl_dispatch #(
    .CORE_COUNT(CORE_COUNT)
  ) dispatch_i (
    .core_clk       (core_clk),
    .core_rst       (core_rst),
    .ctrl_in        (ctrl_in),
    .ctrl_in_dest   (ctrl_in_dest),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .core_ctrl      (core_ctrl),
    .core_ctrl_valid(core_ctrl_valid),
    .core_ctrl_ready(core_ctrl_ready)
  );

  ctrl_collect #(
    .CORE_COUNT(CORE_COUNT)
  ) collect_i (
    .core_clk           (core_clk),
    .core_rst           (core_rst),
    .core_ctrl_out      (core_ctrl_out),
    .core_ctrl_out_valid(core_ctrl_out_valid),
    .core_ctrl_out_ready(core_ctrl_out_ready),
    .ctrl_out           (ctrl_out),
    .ctrl_out_src       (ctrl_out_src),
    .ctrl_out_valid     (ctrl_out_valid),
    .ctrl_out_ready     (ctrl_out_ready)
  );

  msg_broadcast #(
    .CORE_COUNT(CORE_COUNT)
  ) broadcast_i (
    .core_clk     (core_clk),
    .core_rst     (core_rst),
    .msg_out      (msg_out),
    .msg_out_valid(msg_out_valid),
    .msg_out_ready(msg_out_ready),
    .msg_in       (msg_in),
    .msg_in_valid (msg_in_valid)
  );

endmodule

//--- hdl/msg_broadcast.sv
`timescale 1ns/1ps

module msg_broadcast #(
  parameter  int CORE_COUNT = 16,
  localparam int IDX_WIDTH  = $clog2(CORE_COUNT)
) (
  input  logic                                   core_clk,
  input  logic                                   core_rst,
  input  fabric_pkg::core_msg_t [CORE_COUNT-1:0] msg_out,
  input  logic [CORE_COUNT-1:0]                  msg_out_valid,
  output logic [CORE_COUNT-1:0]                  msg_out_ready,
  output fabric_pkg::core_msg_t                  msg_in,
  output logic [CORE_COUNT-1:0]                  msg_in_valid
);

  logic [CORE_COUNT-1:0] win_grant;
  logic [IDX_WIDTH-1:0]  win_idx;
  logic                  win_valid;
  logic                  bcast_valid;
  logic [CORE_COUNT-1:0] bcast_mask;

  // One winner per cycle, pointer moves on every grant
  rr_arbiter #(
    .CORE_COUNT(CORE_COUNT)
  ) arb_i (
    .core_clk   (core_clk),
    .core_rst   (core_rst),
    .req        (msg_out_valid),
    .advance    (win_valid),
    .grant      (win_grant),
    .grant_idx  (win_idx),
    .grant_valid(win_valid)
  );

  // Messages are single beat, so the winner is accepted at once
  assign msg_out_ready = win_grant;

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      bcast_valid <= 1'b0;
    end else begin
      bcast_valid <= win_valid;
    end
  end

  // Sender is masked out of its own broadcast
  always_ff @(posedge core_clk) begin
    if (win_valid) begin
      msg_in     <= msg_out[win_idx];
      bcast_mask <= ~win_grant;
    end
  end

  assign msg_in_valid = {CORE_COUNT{bcast_valid}} & bcast_mask;

  no_self_a: assert property (
    @(posedge core_clk) disable iff (core_rst) !(&msg_in_valid)
  ) else $error("msg_broadcast: message echoed to every core");

endmodule

//--- hdl/ctrl_collect.sv
`timescale 1ns/1ps

module ctrl_collect #(
  parameter  int CORE_COUNT = 16,
  localparam int IDX_WIDTH  = $clog2(CORE_COUNT)
) (
  input  logic                                    core_clk,
  input  logic                                    core_rst,
  input  fabric_pkg::ctrl_beat_t [CORE_COUNT-1:0] core_ctrl_out,
  input  logic [CORE_COUNT-1:0]                   core_ctrl_out_valid,
  output logic [CORE_COUNT-1:0]                   core_ctrl_out_ready,
  output fabric_pkg::ctrl_beat_t                  ctrl_out,
  output logic [IDX_WIDTH-1:0]                    ctrl_out_src,
  output logic                                    ctrl_out_valid,
  input  logic                                    ctrl_out_ready
);

  import fabric_pkg::*;

  collect_state_e        state;
  logic [IDX_WIDTH-1:0]  lock_idx;
  logic [CORE_COUNT-1:0] arb_req;
  logic [CORE_COUNT-1:0] arb_grant;
  logic [IDX_WIDTH-1:0]  arb_idx;
  logic                  arb_valid;
  logic                  arb_advance;
  logic                  out_space;
  logic                  take;
  ctrl_beat_t            sel_beat;

  // While a packet is locked the arbiter only sees the locked core,
  // so its grant and index stay on that core until advance
  assign arb_req = (state == COLLECT_BUSY) ? (CORE_COUNT'(1) << lock_idx)
                                           : core_ctrl_out_valid;

  rr_arbiter #(
    .CORE_COUNT(CORE_COUNT)
  ) arb_i (
    .core_clk   (core_clk),
    .core_rst   (core_rst),
    .req        (arb_req),
    .advance    (arb_advance),
    .grant      (arb_grant),
    .grant_idx  (arb_idx),
    .grant_valid(arb_valid)
  );

  assign out_space = !ctrl_out_valid || ctrl_out_ready;

  // Only the locked core is offered ready
  assign core_ctrl_out_ready = (state == COLLECT_BUSY && out_space) ? arb_grant : '0;

  assign sel_beat    = core_ctrl_out[lock_idx];
  assign take        = |(core_ctrl_out_ready & core_ctrl_out_valid);
  assign arb_advance = take && sel_beat.last;

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      state    <= COLLECT_IDLE;
      lock_idx <= '0;
    end else begin
      case (state)
        COLLECT_IDLE: begin
          if (arb_valid) begin
            state    <= COLLECT_BUSY;
            lock_idx <= arb_idx;
          end
        end
        COLLECT_BUSY: begin
          if (arb_advance) begin
            state <= COLLECT_IDLE;
          end
        end
        default: state <= COLLECT_IDLE;
      endcase
    end
  end

  // Output register
  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      ctrl_out_valid <= 1'b0;
    end else if (take) begin
      ctrl_out_valid <= 1'b1;
    end else if (ctrl_out_ready) begin
      ctrl_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (take) begin
      ctrl_out     <= sel_beat;
      ctrl_out_src <= lock_idx;
    end
  end

  // No other source can slip into a locked packet
  src_stable_a: assert property (
    @(posedge core_clk) disable iff (core_rst)
    (state == COLLECT_BUSY && ctrl_out_valid && ctrl_out_src == lock_idx)
      |=> $stable(ctrl_out_src)
  ) else $error("ctrl_collect: source changed inside a packet");

endmodule

//--- hdl/ctrl_dispatch.sv
`timescale 1ns/1ps

module ctrl_dispatch #(
  parameter  int CORE_COUNT = 16,
  localparam int IDX_WIDTH  = $clog2(CORE_COUNT)
) (
  input  logic                   core_clk,
  input  logic                   core_rst,
  input  fabric_pkg::ctrl_beat_t ctrl_in,
  input  logic [IDX_WIDTH-1:0]   ctrl_in_dest,
  input  logic                   ctrl_in_valid,
  output logic                   ctrl_in_ready,
  output fabric_pkg::ctrl_beat_t core_ctrl,
  output logic [CORE_COUNT-1:0]  core_ctrl_valid,
  input  logic [CORE_COUNT-1:0]  core_ctrl_ready
);

  logic                 accept_en;
  logic                 out_valid;
  logic [IDX_WIDTH-1:0] out_dest;
  logic                 mid_packet;
  logic [IDX_WIDTH-1:0] dest_sel;
  logic                 in_fire;
  logic                 out_fire;

  // Output stage drains when its destination core takes the beat
  assign out_fire = out_valid && core_ctrl_ready[out_dest];

  // Held low until the first cycle out of reset
  assign ctrl_in_ready = accept_en && (!out_valid || out_fire);
  assign in_fire       = ctrl_in_valid && ctrl_in_ready;

  // Later beats of a packet follow the destination of its first beat,
  // which still sits in out_dest
  assign dest_sel = mid_packet ? out_dest : ctrl_in_dest;

  assign core_ctrl_valid = out_valid ? (CORE_COUNT'(1) << out_dest) : '0;

  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      accept_en  <= 1'b0;
      out_valid  <= 1'b0;
      mid_packet <= 1'b0;
    end else begin
      accept_en <= 1'b1;
      if (in_fire) begin
        out_valid  <= 1'b1;
        mid_packet <= !ctrl_in.last;
      end else if (out_fire) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload and destination of the output stage
  always_ff @(posedge core_clk) begin
    if (in_fire) begin
      core_ctrl <= ctrl_in;
      out_dest  <= dest_sel;
    end
  end

  valid_onehot_a: assert property (
    @(posedge core_clk) disable iff (core_rst) $onehot0(core_ctrl_valid)
  ) else $error("ctrl_dispatch: more than one core sees valid");

  // A stalled beat must not move or change target
  hold_a: assert property (
    @(posedge core_clk) disable iff (core_rst)
    (|core_ctrl_valid && !(|(core_ctrl_valid & core_ctrl_ready)))
      |=> ($stable(core_ctrl_valid) && $stable(core_ctrl))
  ) else $error("ctrl_dispatch: stalled beat changed");

endmodule

//--- hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
  parameter  int CORE_COUNT = 16,
  localparam int IDX_WIDTH  = $clog2(CORE_COUNT)
) (
  input  logic                  core_clk,
  input  logic                  core_rst,
  input  logic [CORE_COUNT-1:0] req,
  input  logic                  advance,
  output logic [CORE_COUNT-1:0] grant,
  output logic [IDX_WIDTH-1:0]  grant_idx,
  output logic                  grant_valid
);

  // Index of the core granted last
  logic [IDX_WIDTH-1:0] last_ptr;

  // Scan upward from the core after the last grant, wrapping around
  always_comb begin
    int unsigned idx;
    grant       = '0;
    grant_idx   = '0;
    grant_valid = 1'b0;
    for (int i = 1; i <= CORE_COUNT; i++) begin
      idx = (int'(last_ptr) + i) % CORE_COUNT;
      if (!grant_valid && req[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = IDX_WIDTH'(idx);
        grant[idx]  = 1'b1;
      end
    end
  end

  // Core 0 gets first priority out of reset
  always_ff @(posedge core_clk) begin
    if (core_rst) begin
      last_ptr <= IDX_WIDTH'(CORE_COUNT - 1);
    end else if (advance && grant_valid) begin
      last_ptr <= grant_idx;
    end
  end

  grant_onehot_a: assert property (
    @(posedge core_clk) disable iff (core_rst) $onehot0(grant)
  ) else $error("rr_arbiter: grant is not one-hot");

  grant_valid_a: assert property (
    @(posedge core_clk) disable iff (core_rst) grant_valid == (|req)
  ) else $error("rr_arbiter: grant_valid does not match the requests");

endmodule

//--- hdl/fabric_pkg.sv
package fabric_pkg;

  // Control stream beat width
  localparam int DATA_WIDTH = 64;

  // Word address into a core's shared data memory
  localparam int DMEM_ADDR_WIDTH = 15;

  // One beat of a control packet
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } ctrl_beat_t;

  // Single-beat memory update sent between cores.
  // strb holds the byte write enables for value
  typedef struct packed {
    logic [3:0]                 strb;
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    logic [31:0]                value;
  } core_msg_t;

  // Collector packet lock
  typedef enum logic [0:0] {
    COLLECT_IDLE = 1'b0,
    COLLECT_BUSY = 1'b1
  } collect_state_e;

endpackage
